// ==== flist.f ====
hdl/pu_pkg.sv
hdl/pu_if.sv
hdl/pu_memctrl.sv
hdl/pu_decode.sv
hdl/pu_execute.sv
hdl/pu_result.sv
hdl/pu_top.sv
test/tb_pu_mem.sv
test/pu_chk.sv
test/tb_pu.sv

// ==== hdl/pu_decode.sv ====
////////////////////////////////////////
// program counter, fetch and decode.
////////////////////////////////////////

`timescale 1ns/1ps

module pu_decode (
	input logic clk_i,
	input logic rst_n_i,
	input logic [pu_pkg::ADDRBITSZ-1:0] rstaddr_i,
	mem_req_if.cli fetch,
	dec_exe_if.dec de,
	res_dec_if.dec rd_port
);

	typedef enum logic [2:0] {
		S_FETCH,
		S_WAIT,
		S_ISSUE,
		S_WAIT_RETIRE,
		S_STOPPED
	} state_e;

	state_e state;
	logic [pu_pkg::ADDRBITSZ-1:0] pc;
	logic [pu_pkg::ADDRBITSZ-1:0] pc_next;
	logic [pu_pkg::ARCHBITSZ-1:0] instr;

	// the counter only moves on retire, so it addresses the fetch directly.
	assign fetch.op = pu_pkg::MEMREADOP;
	assign fetch.addr = pc;
	assign fetch.wdata = '0;

	assign pc_next = rd_port.jump ? rd_port.jump_addr : pc + 1'b1;

	// the register file answers combinationally from the held instruction.
	assign rd_port.ra_idx = instr[pu_pkg::RD_LSB +: pu_pkg::GPRIDXSZ];
	assign rd_port.rb_idx = instr[pu_pkg::RS_LSB +: pu_pkg::GPRIDXSZ];

	assign de.issue = (state == S_ISSUE);
	assign de.opcode = pu_pkg::opcode_e'(instr[pu_pkg::OPC_LSB +: pu_pkg::OPC_BITSZ]);
	assign de.rd = instr[pu_pkg::RD_LSB +: pu_pkg::GPRIDXSZ];
	assign de.a = rd_port.ra_val;
	assign de.b = rd_port.rb_val;
	assign de.imm = instr[pu_pkg::IMM_BITSZ-1:0];

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state <= S_FETCH;
			pc <= rstaddr_i;
			fetch.req <= 1'b0;
		end else begin
			case (state)
				S_FETCH: begin
					fetch.req <= 1'b1;
					state <= S_WAIT;
				end
				S_WAIT: begin
					if (fetch.done) begin
						fetch.req <= 1'b0;
						instr <= fetch.rdata;
						state <= S_ISSUE;
					end
				end
				S_ISSUE: state <= S_WAIT_RETIRE;
				S_WAIT_RETIRE: begin
					if (rd_port.retire) begin
						pc <= pc_next;
						if (rd_port.halted) begin
							state <= S_STOPPED;
						end else begin
							// next fetch goes out straight away.
							fetch.req <= 1'b1;
							state <= S_WAIT;
						end
					end
				end
				default: state <= S_STOPPED;
			endcase
		end
	end

endmodule

// ==== hdl/pu_execute.sv ====
////////////////////////////////////////
// ALU, load/store and jump target.
////////////////////////////////////////

`timescale 1ns/1ps

module pu_execute (
	input logic clk_i,
	input logic rst_n_i,
	input logic [pu_pkg::ARCHBITSZ-1:0] id_i,
	dec_exe_if.exe de,
	mem_req_if.cli data,
	exe_res_if.exe er
);

	typedef enum logic {S_IDLE, S_MEM} state_e;

	state_e state;
	logic [pu_pkg::ARCHBITSZ-1:0] imm_sx;
	logic [pu_pkg::ARCHBITSZ-1:0] alu_res;
	logic alu_wr;
	logic is_ld;
	logic is_st;

	assign imm_sx = {{(pu_pkg::ARCHBITSZ - pu_pkg::IMM_BITSZ){de.imm[pu_pkg::IMM_BITSZ-1]}},
		de.imm};

	assign is_ld = (de.opcode == pu_pkg::OP_LD);
	assign is_st = (de.opcode == pu_pkg::OP_ST);

	always_comb begin
		alu_res = '0;
		alu_wr = 1'b1;
		case (de.opcode)
			pu_pkg::OP_ADD: alu_res = de.a + de.b;
			pu_pkg::OP_SUB: alu_res = de.a - de.b;
			pu_pkg::OP_AND: alu_res = de.a & de.b;
			pu_pkg::OP_OR: alu_res = de.a | de.b;
			pu_pkg::OP_XOR: alu_res = de.a ^ de.b;
			pu_pkg::OP_LI: alu_res = imm_sx;
			pu_pkg::OP_GETID: alu_res = id_i;
			default: alu_wr = 1'b0;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state <= S_IDLE;
			er.done <= 1'b0;
			data.req <= 1'b0;
		end else begin
			er.done <= 1'b0;
			case (state)
				S_IDLE: begin
					if (de.issue) begin
						er.wr_idx <= de.rd;
						er.jump <= (de.opcode == pu_pkg::OP_JR);
						er.jump_addr <= de.b[pu_pkg::ADDRBITSZ-1:0];
						er.halt <= (de.opcode == pu_pkg::OP_HALT);
						if (is_ld || is_st) begin
							// a store sends rd to the word that rs points at.
							er.wr_en <= is_ld;
							data.req <= 1'b1;
							data.op <= is_ld ? pu_pkg::MEMREADOP : pu_pkg::MEMWRITEOP;
							data.addr <= de.b[pu_pkg::ADDRBITSZ-1:0];
							data.wdata <= de.a;
							state <= S_MEM;
						end else begin
							er.wr_en <= alu_wr;
							er.wr_data <= alu_res;
							er.done <= 1'b1;
						end
					end
				end
				S_MEM: begin
					if (data.done) begin
						data.req <= 1'b0;
						er.wr_data <= data.rdata;
						er.done <= 1'b1;
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// ==== hdl/pu_if.sv ====
////////////////////////////////////////
// interfaces between decode, execute,
// result and the memory controller.
////////////////////////////////////////

`timescale 1ns/1ps

interface dec_exe_if;
	logic issue;
	pu_pkg::opcode_e opcode;
	logic [pu_pkg::GPRIDXSZ-1:0] rd;
	logic [pu_pkg::ARCHBITSZ-1:0] a;
	logic [pu_pkg::ARCHBITSZ-1:0] b;
	logic [pu_pkg::IMM_BITSZ-1:0] imm;

	modport dec (output issue, opcode, rd, a, b, imm);
	modport exe (input issue, opcode, rd, a, b, imm);
endinterface

interface exe_res_if;
	logic done;
	logic wr_en;
	logic [pu_pkg::GPRIDXSZ-1:0] wr_idx;
	logic [pu_pkg::ARCHBITSZ-1:0] wr_data;
	logic jump;
	logic [pu_pkg::ADDRBITSZ-1:0] jump_addr;
	logic halt;

	modport exe (output done, wr_en, wr_idx, wr_data, jump, jump_addr, halt);
	modport res (input done, wr_en, wr_idx, wr_data, jump, jump_addr, halt);
endinterface

interface res_dec_if;
	logic [pu_pkg::GPRIDXSZ-1:0] ra_idx;
	logic [pu_pkg::GPRIDXSZ-1:0] rb_idx;
	logic [pu_pkg::ARCHBITSZ-1:0] ra_val;
	logic [pu_pkg::ARCHBITSZ-1:0] rb_val;
	logic retire;
	logic jump;
	logic [pu_pkg::ADDRBITSZ-1:0] jump_addr;
	logic halted;

	modport res (input ra_idx, rb_idx, output ra_val, rb_val, retire, jump, jump_addr, halted);
	modport dec (output ra_idx, rb_idx, input ra_val, rb_val, retire, jump, jump_addr, halted);
endinterface

// req and its fields hold still from raise until done.
interface mem_req_if;
	logic req;
	pu_pkg::mem_op_e op;
	logic [pu_pkg::ADDRBITSZ-1:0] addr;
	logic [pu_pkg::ARCHBITSZ-1:0] wdata;
	logic [pu_pkg::ARCHBITSZ-1:0] rdata;
	logic done;

	modport cli (output req, op, addr, wdata, input rdata, done);
	modport mem (input req, op, addr, wdata, output rdata, done);
endinterface

// ==== hdl/pu_memctrl.sv ====
////////////////////////////////////////
// pi1 memory controller, fetch and data.
////////////////////////////////////////

`timescale 1ns/1ps

module pu_memctrl (
	input logic clk_i,
	input logic rst_n_i,
	mem_req_if.mem fetch,
	mem_req_if.mem data,
	output pu_pkg::mem_op_e pi1_op_o,
	output logic [pu_pkg::ADDRBITSZ-1:0] pi1_addr_o,
	output logic [pu_pkg::ARCHBITSZ-1:0] pi1_data_o,
	output logic [pu_pkg::SELBITSZ-1:0] pi1_sel_o,
	input logic [pu_pkg::ARCHBITSZ-1:0] pi1_data_i,
	input logic pi1_rdy_i
);

	typedef enum logic {S_IDLE, S_BUSY} state_e;

	state_e state;
	logic sel_data;
	logic fetch_done;
	logic data_done;
	logic [pu_pkg::ARCHBITSZ-1:0] rdata;

	assign fetch.rdata = rdata;
	assign data.rdata = rdata;
	assign fetch.done = fetch_done;
	assign data.done = data_done;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state <= S_IDLE;
			sel_data <= 1'b0;
			fetch_done <= 1'b0;
			data_done <= 1'b0;
			pi1_op_o <= pu_pkg::MEMNOOP;
			pi1_sel_o <= '0;
		end else begin
			fetch_done <= 1'b0;
			data_done <= 1'b0;
			case (state)
				S_IDLE: begin
					// the client still holds req while done is high.
					if (!fetch_done && !data_done && (data.req || fetch.req)) begin
						// data access goes first.
						sel_data <= data.req;
						pi1_op_o <= data.req ? data.op : fetch.op;
						pi1_addr_o <= data.req ? data.addr : fetch.addr;
						pi1_data_o <= data.req ? data.wdata : fetch.wdata;
						pi1_sel_o <= '1;
						state <= S_BUSY;
					end
				end
				S_BUSY: begin
					if (pi1_rdy_i) begin
						rdata <= pi1_data_i;
						fetch_done <= !sel_data;
						data_done <= sel_data;
						pi1_op_o <= pu_pkg::MEMNOOP;
						pi1_sel_o <= '0;
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// ==== hdl/pu_pkg.sv ====
////////////////////////////////////////
// sizes, bus operation codes, opcodes
// and instruction field positions.
////////////////////////////////////////

package pu_pkg;

	// data word and word address widths.
	localparam int ARCHBITSZ = 32;
	localparam int ADDRBITSZ = 30;

	// one select bit per byte of a word.
	localparam int SELBITSZ = ARCHBITSZ / 8;

	// general registers.
	localparam int GPRCNT = 16;
	localparam int GPRIDXSZ = 4;

	// instruction word layout, from the top bit down.
	// the opcode comes first, then rd, then rs, and the immediate
	// fills the remaining low bits.
	localparam int OPC_BITSZ = 4;
	localparam int OPC_LSB = ARCHBITSZ - OPC_BITSZ;
	localparam int RD_LSB = OPC_LSB - GPRIDXSZ;
	localparam int RS_LSB = RD_LSB - GPRIDXSZ;
	localparam int IMM_BITSZ = RS_LSB;

	// pi1 bus operation codes.
	typedef enum logic [1:0] {
		MEMNOOP        = 2'b00,
		MEMWRITEOP     = 2'b01,
		MEMREADOP      = 2'b10,
		MEMREADWRITEOP = 2'b11
	} mem_op_e;

	// ALU operations compute rd = rd op rs and wrap around.
	// loads and stores take the word address from the low bits of rs.
	// unlisted encodings only retire.
	typedef enum logic [OPC_BITSZ-1:0] {
		OP_ADD   = 4'h0,
		OP_SUB   = 4'h1,
		OP_AND   = 4'h2,
		OP_OR    = 4'h3,
		OP_XOR   = 4'h4,
		OP_LI    = 4'h5,
		OP_LD    = 4'h6,
		OP_ST    = 4'h7,
		OP_JR    = 4'h8,
		OP_GETID = 4'h9,
		OP_HALT  = 4'ha
	} opcode_e;

endpackage

// ==== hdl/pu_result.sv ====
////////////////////////////////////////
// register file, write-back and halt.
////////////////////////////////////////

`timescale 1ns/1ps

module pu_result (
	input logic clk_i,
	input logic rst_n_i,
	exe_res_if.res er,
	res_dec_if.res rd_port,
	output logic halted_o
);

	logic [pu_pkg::ARCHBITSZ-1:0] gpr [pu_pkg::GPRCNT];
	logic halted_q;

	// operand read needs no clock edge.
	assign rd_port.ra_val = gpr[rd_port.ra_idx];
	assign rd_port.rb_val = gpr[rd_port.rb_idx];

	assign rd_port.halted = halted_q;
	assign halted_o = halted_q;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < pu_pkg::GPRCNT; i++) begin
				gpr[i] <= '0;
			end
			rd_port.retire <= 1'b0;
			rd_port.jump <= 1'b0;
			halted_q <= 1'b0;
		end else begin
			rd_port.retire <= er.done;
			rd_port.jump <= er.done && er.jump;
			rd_port.jump_addr <= er.jump_addr;
			if (er.done && er.wr_en) begin
				gpr[er.wr_idx] <= er.wr_data;
			end
			// halted rises together with the retire of the halt.
			if (er.done && er.halt) begin
				halted_q <= 1'b1;
			end
		end
	end

endmodule

// ==== hdl/pu_top.sv ====
////////////////////////////////////////
// processing unit top level.
////////////////////////////////////////

`timescale 1ns/1ps

module pu_top (
	input logic clk_i,
	input logic rst_n_i,
	output pu_pkg::mem_op_e pi1_op_o,
	output logic [pu_pkg::ADDRBITSZ-1:0] pi1_addr_o,
	output logic [pu_pkg::ARCHBITSZ-1:0] pi1_data_o,
	input logic [pu_pkg::ARCHBITSZ-1:0] pi1_data_i,
	output logic [pu_pkg::SELBITSZ-1:0] pi1_sel_o,
	input logic pi1_rdy_i,
	output logic halted_o,
	input logic [pu_pkg::ADDRBITSZ-1:0] rstaddr_i,
	input logic [pu_pkg::ARCHBITSZ-1:0] id_i
);

	dec_exe_if de_bus ();
	exe_res_if er_bus ();
	res_dec_if rd_bus ();
	mem_req_if fetch_bus ();
	mem_req_if data_bus ();

	pu_memctrl i_memctrl (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.fetch(fetch_bus.mem),
		.data(data_bus.mem),
		.pi1_op_o(pi1_op_o),
		.pi1_addr_o(pi1_addr_o),
		.pi1_data_o(pi1_data_o),
		.pi1_sel_o(pi1_sel_o),
		.pi1_data_i(pi1_data_i),
		.pi1_rdy_i(pi1_rdy_i)
	);

	pu_decode i_decode (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.rstaddr_i(rstaddr_i),
		.fetch(fetch_bus.cli),
		.de(de_bus.dec),
		.rd_port(rd_bus.dec)
	);

	pu_execute i_execute (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.id_i(id_i),
		.de(de_bus.exe),
		.data(data_bus.cli),
		.er(er_bus.exe)
	);

	pu_result i_result (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.er(er_bus.res),
		.rd_port(rd_bus.res),
		.halted_o(halted_o)
	);

endmodule

// ==== test/pu_chk.sv ====
////////////////////////////////////////
// pi1 and halt assertions, bound to top.
////////////////////////////////////////

`timescale 1ns/1ps

module pu_chk (
	input logic clk_i,
	input logic rst_n_i,
	input pu_pkg::mem_op_e pi1_op_o,
	input logic [pu_pkg::ADDRBITSZ-1:0] pi1_addr_o,
	input logic [pu_pkg::ARCHBITSZ-1:0] pi1_data_o,
	input logic [pu_pkg::SELBITSZ-1:0] pi1_sel_o,
	input logic pi1_rdy_i,
	input logic halted_o
);

	// number of assertion failures so far.
	int fail_cnt = 0;

	// a waiting request holds still until ready.
	a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(pi1_op_o != pu_pkg::MEMNOOP && !pi1_rdy_i) |=>
		($stable(pi1_op_o) && $stable(pi1_addr_o) && $stable(pi1_data_o) && $stable(pi1_sel_o)))
		else begin
			fail_cnt++;
			$error("pi1 request changed before ready");
		end

	a_sel_active: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		((pi1_sel_o == '1) == (pi1_op_o != pu_pkg::MEMNOOP)))
		else begin
			fail_cnt++;
			$error("pi1_sel_o does not match an active transfer");
		end

	a_halt_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		halted_o |=> halted_o)
		else begin
			fail_cnt++;
			$error("halted_o dropped without reset");
		end

	a_halt_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		halted_o |-> (pi1_op_o == pu_pkg::MEMNOOP))
		else begin
			fail_cnt++;
			$error("pi1 transfer issued while halted");
		end

endmodule

bind pu_top pu_chk i_chk (
	.clk_i(clk_i),
	.rst_n_i(rst_n_i),
	.pi1_op_o(pi1_op_o),
	.pi1_addr_o(pi1_addr_o),
	.pi1_data_o(pi1_data_o),
	.pi1_sel_o(pi1_sel_o),
	.pi1_rdy_i(pi1_rdy_i),
	.halted_o(halted_o)
);

// ==== test/tb_pu.sv ====
////////////////////////////////////////
// testbench with directed program tests.
////////////////////////////////////////

`timescale 1ns/1ps

module tb_pu;

	localparam logic [31:0] SEED = 32'ha425_f48e;
	localparam logic [31:0] ID_WORD = 32'h5055_0001;
	localparam int DATA_BASE = 512;
	localparam int ALU_LEN = 22;
	localparam int SEXT_LEN = 7;
	localparam int LDST_LEN = 7;
	localparam int JUMP_LEN = 8;
	localparam int HALT_LEN = 4;
	localparam int INSTR_TOTAL = 2 * ALU_LEN + SEXT_LEN + LDST_LEN + JUMP_LEN + HALT_LEN;
	// two transfers of four cycles each plus pipeline overhead.
	localparam int MAX_CPI = 16;
	localparam int TIMEOUT = 2 * (INSTR_TOTAL * MAX_CPI + 6 * 24);

	logic clk_i;
	logic rst_n_i;
	logic [pu_pkg::ADDRBITSZ-1:0] rstaddr;
	logic [31:0] id_word;
	logic stall;
	pu_pkg::mem_op_e pi1_op;
	logic [pu_pkg::ADDRBITSZ-1:0] pi1_addr;
	logic [31:0] pi1_wdata;
	logic [31:0] pi1_rdata;
	logic [pu_pkg::SELBITSZ-1:0] pi1_sel;
	logic pi1_rdy;
	logic halted;
	integer seed;
	int errors;
	int checks;
	int cycles = 0;
	logic [31:0] prog [$];
	logic [19:0] alu_a;
	logic [19:0] alu_b;
	pu_pkg::opcode_e alu_ops [5] = '{pu_pkg::OP_ADD, pu_pkg::OP_SUB, pu_pkg::OP_AND,
		pu_pkg::OP_OR, pu_pkg::OP_XOR};

	always #50 clk_i = ~clk_i;

	pu_top i_dut (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.pi1_op_o(pi1_op),
		.pi1_addr_o(pi1_addr),
		.pi1_data_o(pi1_wdata),
		.pi1_data_i(pi1_rdata),
		.pi1_sel_o(pi1_sel),
		.pi1_rdy_i(pi1_rdy),
		.halted_o(halted),
		.rstaddr_i(rstaddr),
		.id_i(id_word)
	);

	tb_pu_mem #(.SEED(SEED)) i_mem (
		.clk_i(clk_i),
		.op_i(pi1_op),
		.addr_i(pi1_addr),
		.data_i(pi1_wdata),
		.data_o(pi1_rdata),
		.rdy_o(pi1_rdy),
		.stall_i(stall)
	);

	function automatic logic [31:0] sext(input logic [19:0] imm);
		return $signed(imm);
	endfunction

	function automatic logic [31:0] fill(input int addr);
		return 32'h3c00_0000 ^ (addr * 32'h0001_0193);
	endfunction

	function automatic logic [31:0] alu_expect(input pu_pkg::opcode_e op, input logic [31:0] a,
		input logic [31:0] b);
		case (op)
			pu_pkg::OP_ADD: return a + b;
			pu_pkg::OP_SUB: return a - b;
			pu_pkg::OP_AND: return a & b;
			pu_pkg::OP_OR: return a | b;
			default: return a ^ b;
		endcase
	endfunction

	task automatic emit(input pu_pkg::opcode_e op, input logic [3:0] rd, input logic [3:0] rs,
		input logic [19:0] imm);
		prog.push_back({op, rd, rs, imm});
	endtask

	// loads the program at base while the DUT is held in reset, then runs it to the halt.
	task automatic run_prog(input int base, input logic stall_en);
		@(negedge clk_i);
		rst_n_i = 1'b0;
		rstaddr = base;
		stall = stall_en;
		for (int i = 0; i < 1024; i++) begin
			i_mem.mem[i] = fill(i);
			i_mem.rd_cnt[i] = 0;
		end
		foreach (prog[i]) begin
			i_mem.mem[base + i] = prog[i];
		end
		prog.delete();
		repeat (2) @(negedge clk_i);
		rst_n_i = 1'b1;
		while (!halted) @(negedge clk_i);
	endtask

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("mismatch at %0d ns: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_mem(input int addr, input logic [31:0] exp);
		check_word($sformatf("mem[%0d]", addr), i_mem.mem[addr], exp);
	endtask

	task automatic test_alu(input logic stall_en);
		emit(pu_pkg::OP_LI, 2, 0, alu_b);
		for (int k = 0; k < 5; k++) begin
			emit(pu_pkg::OP_LI, 3, 0, alu_a);
			emit(alu_ops[k], 3, 2, 0);
			emit(pu_pkg::OP_LI, 9, 0, DATA_BASE + k);
			emit(pu_pkg::OP_ST, 3, 9, 0);
		end
		emit(pu_pkg::OP_HALT, 0, 0, 0);
		run_prog(0, stall_en);
		for (int k = 0; k < 5; k++) begin
			check_mem(DATA_BASE + k, alu_expect(alu_ops[k], sext(alu_a), sext(alu_b)));
		end
	endtask

	task automatic test_sext();
		emit(pu_pkg::OP_LI, 1, 0, 20'h80001);
		emit(pu_pkg::OP_LI, 2, 0, 20'h7fffe);
		emit(pu_pkg::OP_LI, 9, 0, 530);
		emit(pu_pkg::OP_ST, 1, 9, 0);
		emit(pu_pkg::OP_LI, 9, 0, 531);
		emit(pu_pkg::OP_ST, 2, 9, 0);
		emit(pu_pkg::OP_HALT, 0, 0, 0);
		run_prog(0, 1'b0);
		check_mem(530, 32'hfff8_0001);
		check_mem(531, 32'h0007_fffe);
	endtask

	task automatic test_ldst();
		emit(pu_pkg::OP_LI, 1, 0, 600);
		emit(pu_pkg::OP_LD, 2, 1, 0);
		emit(pu_pkg::OP_LI, 3, 0, 1);
		emit(pu_pkg::OP_ADD, 2, 3, 0);
		emit(pu_pkg::OP_LI, 4, 0, 601);
		emit(pu_pkg::OP_ST, 2, 4, 0);
		emit(pu_pkg::OP_HALT, 0, 0, 0);
		run_prog(0, 1'b0);
		check_mem(601, fill(600) + 32'd1);
	endtask

	task automatic test_jump();
		emit(pu_pkg::OP_LI, 1, 0, 620);
		emit(pu_pkg::OP_GETID, 2, 0, 0);
		emit(pu_pkg::OP_ST, 2, 1, 0);
		emit(pu_pkg::OP_LI, 4, 0, 621);
		emit(pu_pkg::OP_LI, 3, 0, 7);
		emit(pu_pkg::OP_JR, 0, 3, 0);
		// this store sits in the jump shadow and never runs.
		emit(pu_pkg::OP_ST, 2, 4, 0);
		emit(pu_pkg::OP_HALT, 0, 0, 0);
		run_prog(0, 1'b0);
		check_mem(620, ID_WORD);
		check_mem(621, fill(621));
	endtask

	task automatic test_halt();
		emit(pu_pkg::OP_LI, 1, 0, 640);
		emit(pu_pkg::OP_LI, 2, 0, 20'hfffff);
		emit(pu_pkg::OP_ST, 2, 1, 0);
		emit(pu_pkg::OP_HALT, 0, 0, 0);
		run_prog(300, 1'b0);
		check_mem(640, 32'hffff_ffff);
		check_word("reads of mem[300]", i_mem.rd_cnt[300], 32'd1);
		repeat (20) begin
			@(negedge clk_i);
			checks++;
			assert (halted) else begin
				errors++;
				$display("halted_o fell after the halt instruction retired at %0d ns", $time);
			end
		end
		check_word("reads of mem[304]", i_mem.rd_cnt[304], 32'd0);
	endtask

	always @(posedge clk_i) begin
		cycles++;
		if (cycles > TIMEOUT) begin
			$display("timeout after %0d cycles, halted_o was never reached", TIMEOUT);
			$display("checks: %0d, errors: %0d", checks, errors + 1);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	initial begin
		clk_i = 1'b0;
		rst_n_i = 1'b0;
		rstaddr = '0;
		id_word = ID_WORD;
		stall = 1'b0;
		seed = SEED;
		errors = 0;
		checks = 0;
		alu_a = $random(seed);
		alu_b = $random(seed);
		test_alu(1'b0);
		test_sext();
		test_ldst();
		test_jump();
		test_halt();
		test_alu(1'b1);
		// failures of the bound assertions count as errors too.
		errors += i_dut.i_chk.fail_cnt;
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// ==== test/tb_pu_mem.sv ====
////////////////////////////////////////
// pi1 memory model with random ready.
////////////////////////////////////////

`timescale 1ns/1ps

module tb_pu_mem #(
	parameter logic [31:0] SEED = 32'h0
) (
	input logic clk_i,
	input pu_pkg::mem_op_e op_i,
	input logic [pu_pkg::ADDRBITSZ-1:0] addr_i,
	input logic [pu_pkg::ARCHBITSZ-1:0] data_i,
	output logic [pu_pkg::ARCHBITSZ-1:0] data_o,
	output logic rdy_o,
	input logic stall_i
);

	logic [pu_pkg::ARCHBITSZ-1:0] mem [1024];
	int rd_cnt [1024];
	integer seed;
	int wait_cnt;
	logic active;

	initial begin
		seed = SEED;
		data_o = '0;
		rdy_o = 1'b0;
		active = 1'b0;
		wait_cnt = 0;
	end

	// ready changes on the falling edge and the DUT samples it on the rising one.
	always @(negedge clk_i) begin
		if (op_i == pu_pkg::MEMNOOP) begin
			rdy_o <= 1'b0;
			active = 1'b0;
		end else if (!rdy_o) begin
			if (!active) begin
				active = 1'b1;
				wait_cnt = stall_i ? ($random(seed) & 3) : 0;
			end
			if (wait_cnt == 0) begin
				rdy_o <= 1'b1;
				data_o <= mem[addr_i[9:0]];
				if (op_i == pu_pkg::MEMWRITEOP) begin
					mem[addr_i[9:0]] = data_i;
				end
				if (op_i == pu_pkg::MEMREADOP) begin
					rd_cnt[addr_i[9:0]]++;
				end
			end else begin
				wait_cnt--;
			end
		end
	end

endmodule
